// ==== src/lc4_consts.svh ====
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// datapath widths
`define LC4_WORD 16
`define LC4_REG_SEL 3
`define LC4_NZP_W 3

// opcodes of the supported instruction groups
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_CONST 4'b1001

// input queue depth, also the sender's starting credit
`define LC4_INSN_QUEUE_DEPTH 4

// retire side buffering and consumer credit
`define LC4_RETIRE_DEPTH 4
`define LC4_RETIRE_CREDITS 2

`endif

// ==== src/lc4_pkg.sv ====
`default_nettype none
`include "lc4_consts.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD-1:0]    word_t;
    typedef logic [`LC4_REG_SEL-1:0] reg_sel_t;

    // operation class picked by the decoder
    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_NOT,
        ALU_OR,
        ALU_XOR,
        ALU_CONST
    } alu_op_t;

    typedef struct packed {
        word_t    insn;
        reg_sel_t rs_sel;
        reg_sel_t rt_sel;
        reg_sel_t rd_sel;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        alu_op_t  op;
        // second operand comes from the 5-bit immediate
        logic     use_imm;
    } decoded_t;

    // one record per instruction leaving writeback
    typedef struct packed {
        word_t                 insn;
        logic                  rd_we;
        reg_sel_t              rd_sel;
        word_t                 rd_data;
        logic [`LC4_NZP_W-1:0] nzp;
    } retire_t;

endpackage

`default_nettype wire

// ==== src/credit_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     gwe,
    input  logic     i_arst_n,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full,
    output logic     o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) wr_ptr <= ptr_inc(wr_ptr);
            if (i_pop) rd_ptr <= ptr_inc(rd_ptr);
            count    <= count + CNT_W'(i_push) - CNT_W'(i_pop);
            // one credit back per freed slot
            o_credit <= i_pop;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_push) mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));

    // the producer must respect its credits
    a_no_push_full: assert property (
        @(posedge gwe) disable iff (!i_arst_n) i_push |-> !o_full)
        else $error("credit_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge gwe) disable iff (!i_arst_n) i_pop |-> !o_empty)
        else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== src/lc4_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::decoded_t o_dec
);

    import lc4_pkg::*;

    logic [3:0] opcode;
    logic [1:0] sub_op;
    logic       imm_form;
    alu_op_t    op;

    assign opcode   = i_insn[15:12];
    assign sub_op   = i_insn[4:3];
    assign imm_form = i_insn[5];

    // MUL and DIV fall through as no-ops
    always_comb begin
        op = ALU_NONE;
        case (opcode)
            `LC4_OP_ARITH: begin
                if (imm_form || sub_op == 2'b00) op = ALU_ADD;
                else if (sub_op == 2'b10) op = ALU_SUB;
            end
            `LC4_OP_LOGIC: begin
                if (imm_form) op = ALU_AND;
                else if (sub_op == 2'b00) op = ALU_AND;
                else if (sub_op == 2'b01) op = ALU_NOT;
                else if (sub_op == 2'b10) op = ALU_OR;
                else op = ALU_XOR;
            end
            `LC4_OP_CONST: op = ALU_CONST;
            default: op = ALU_NONE;
        endcase
    end

    always_comb begin
        o_dec.insn    = i_insn;
        o_dec.rd_sel  = i_insn[11:9];
        o_dec.rs_sel  = i_insn[8:6];
        o_dec.rt_sel  = i_insn[2:0];
        o_dec.op      = op;
        o_dec.use_imm = imm_form && (op == ALU_ADD || op == ALU_AND);
        o_dec.rd_we   = (op != ALU_NONE);
        // CONST reads nothing, NOT and immediates skip rt
        o_dec.rs_re   = o_dec.rd_we && (op != ALU_CONST);
        o_dec.rt_re   = o_dec.rs_re && !o_dec.use_imm && (op != ALU_NOT);
    end

endmodule

`default_nettype wire

// ==== src/lc4_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::reg_sel_t i_rs_sel,
    input  lc4_pkg::reg_sel_t i_rt_sel,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_sel_t i_rd_sel,
    input  lc4_pkg::word_t    i_rd_data,
    input  logic              i_rd_we
);

    import lc4_pkg::*;

    localparam int NUM_REGS = 1 << `LC4_REG_SEL;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

`default_nettype wire

// ==== src/lc4_alu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module lc4_alu (
    input  lc4_pkg::decoded_t      i_dec,
    input  lc4_pkg::word_t         i_rs,
    input  lc4_pkg::word_t         i_rt,
    output lc4_pkg::word_t         o_result,
    output logic [`LC4_NZP_W-1:0]  o_nzp
);

    import lc4_pkg::*;

    word_t imm5;
    word_t imm9;
    word_t operand_b;

    assign imm5      = {{(`LC4_WORD - 5){i_dec.insn[4]}}, i_dec.insn[4:0]};
    assign imm9      = {{(`LC4_WORD - 9){i_dec.insn[8]}}, i_dec.insn[8:0]};
    assign operand_b = i_dec.use_imm ? imm5 : i_rt;

    always_comb begin
        case (i_dec.op)
            ALU_ADD:   o_result = i_rs + operand_b;
            ALU_SUB:   o_result = i_rs - operand_b;
            ALU_AND:   o_result = i_rs & operand_b;
            ALU_NOT:   o_result = ~i_rs;
            ALU_OR:    o_result = i_rs | operand_b;
            ALU_XOR:   o_result = i_rs ^ operand_b;
            ALU_CONST: o_result = imm9;
            default:   o_result = '0;
        endcase
    end

    // sign of the result, no bits for a no-op
    always_comb begin
        if (!i_dec.rd_we) o_nzp = 3'b000;
        else if (o_result[`LC4_WORD-1]) o_nzp = 3'b100;
        else if (o_result == '0) o_nzp = 3'b010;
        else o_nzp = 3'b001;
    end

endmodule

`default_nettype wire

// ==== src/lc4_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module lc4_pipeline (
    input  logic             gwe,
    input  logic             i_arst_n,
    input  lc4_pkg::word_t   i_insn,
    input  logic             i_insn_empty,
    output logic             o_insn_pop,
    input  logic             i_retire_full,
    output logic             o_retire_push,
    output lc4_pkg::retire_t o_retire
);

    import lc4_pkg::*;

    logic                  advance;
    logic                  d_valid;
    logic                  x_valid;
    logic                  w_valid;
    word_t                 d_insn;
    decoded_t              d_dec;
    word_t                 d_rs_data;
    word_t                 d_rt_data;
    decoded_t              x_dec;
    word_t                 x_rs;
    word_t                 x_rt;
    word_t                 x_rs_fwd;
    word_t                 x_rt_fwd;
    word_t                 x_result;
    logic [`LC4_NZP_W-1:0] x_nzp;
    retire_t               w_rec;
    logic                  w_writes;

    // retire back-pressure is the only stall
    assign advance       = !i_retire_full;
    assign o_insn_pop    = advance && !i_insn_empty;
    assign o_retire_push = w_valid && advance;
    assign o_retire      = w_rec;
    assign w_writes      = w_valid && w_rec.rd_we;

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_dec  (d_dec)
    );

    // regfile is written once, in the cycle the record leaves
    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (d_dec.rs_sel),
        .i_rt_sel  (d_dec.rt_sel),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data),
        .i_rd_sel  (w_rec.rd_sel),
        .i_rd_data (w_rec.rd_data),
        .i_rd_we   (w_writes && advance)
    );

    // writeback to execute bypass, stays stable while stalled
    assign x_rs_fwd = (x_dec.rs_re && w_writes && w_rec.rd_sel == x_dec.rs_sel) ?
                      w_rec.rd_data : x_rs;
    assign x_rt_fwd = (x_dec.rt_re && w_writes && w_rec.rd_sel == x_dec.rt_sel) ?
                      w_rec.rd_data : x_rt;

    lc4_alu u_alu (
        .i_dec    (x_dec),
        .i_rs     (x_rs_fwd),
        .i_rt     (x_rt_fwd),
        .o_result (x_result),
        .o_nzp    (x_nzp)
    );

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            d_valid <= 1'b0;
            x_valid <= 1'b0;
            w_valid <= 1'b0;
        end else if (advance) begin
            d_valid <= o_insn_pop;
            x_valid <= d_valid;
            w_valid <= x_valid;
        end
    end

    always_ff @(posedge gwe) begin
        if (advance) begin
            d_insn        <= i_insn;
            x_dec         <= d_dec;
            x_rs          <= d_rs_data;
            x_rt          <= d_rt_data;
            w_rec.insn    <= x_dec.insn;
            w_rec.rd_we   <= x_dec.rd_we;
            w_rec.rd_sel  <= x_dec.rd_sel;
            w_rec.rd_data <= x_result;
            w_rec.nzp     <= x_nzp;
        end
    end

endmodule

`default_nettype wire

// ==== src/retire_port.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module retire_port (
    input  logic             gwe,
    input  logic             i_arst_n,
    input  logic             i_push,
    input  lc4_pkg::retire_t i_rec,
    output logic             o_full,
    input  logic             i_retire_credit,
    output logic             o_retire_valid,
    output lc4_pkg::retire_t o_retire
);

    import lc4_pkg::*;

    localparam int CRED_W = $clog2(`LC4_RETIRE_CREDITS + 1);

    retire_t           head;
    logic              empty;
    logic              pop;
    logic [CRED_W-1:0] credits;

    // the fifo credit pulse doubles as the valid strobe
    credit_fifo #(
        .payload_t (retire_t),
        .DEPTH     (`LC4_RETIRE_DEPTH)
    ) u_retire_fifo (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_push   (i_push),
        .i_data   (i_rec),
        .i_pop    (pop),
        .o_data   (head),
        .o_empty  (empty),
        .o_full   (o_full),
        .o_credit (o_retire_valid)
    );

    assign pop = !empty && (credits != '0);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) credits <= CRED_W'(`LC4_RETIRE_CREDITS);
        else credits <= credits + CRED_W'(i_retire_credit) - CRED_W'(pop);
    end

    always_ff @(posedge gwe) begin
        if (pop) o_retire <= head;
    end

    // consumer returns no more credits than it was given
    a_credit_bound: assert property (
        @(posedge gwe) disable iff (!i_arst_n) credits <= CRED_W'(`LC4_RETIRE_CREDITS))
        else $error("retire_port: credit counter above limit");

endmodule

`default_nettype wire

// ==== src/lc4_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module lc4_core (
    input  logic             gwe,
    input  logic             i_arst_n,
    input  logic             i_insn_valid,
    input  lc4_pkg::word_t   i_insn,
    output logic             o_insn_credit,
    input  logic             i_retire_credit,
    output logic             o_retire_valid,
    output lc4_pkg::retire_t o_retire
);

    import lc4_pkg::*;

    word_t   q_head;
    logic    q_empty;
    logic    q_pop;
    retire_t wb_rec;
    logic    wb_push;
    logic    rp_full;

    // input side, sender never overruns thanks to credits
    credit_fifo #(
        .payload_t (word_t),
        .DEPTH     (`LC4_INSN_QUEUE_DEPTH)
    ) u_insn_queue (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_push   (i_insn_valid),
        .i_data   (i_insn),
        .i_pop    (q_pop),
        .o_data   (q_head),
        .o_empty  (q_empty),
        .o_full   (),
        .o_credit (o_insn_credit)
    );

    lc4_pipeline u_pipeline (
        .gwe           (gwe),
        .i_arst_n      (i_arst_n),
        .i_insn        (q_head),
        .i_insn_empty  (q_empty),
        .o_insn_pop    (q_pop),
        .i_retire_full (rp_full),
        .o_retire_push (wb_push),
        .o_retire      (wb_rec)
    );

    retire_port u_retire_port (
        .gwe             (gwe),
        .i_arst_n        (i_arst_n),
        .i_push          (wb_push),
        .i_rec           (wb_rec),
        .o_full          (rp_full),
        .i_retire_credit (i_retire_credit),
        .o_retire_valid  (o_retire_valid),
        .o_retire        (o_retire)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic gwe,
    output logic o_arst_n
);

    initial begin
        gwe = 1'b0;
        forever #(PERIOD_NS / 2) gwe = ~gwe;
    end

    // release just after an edge, clear of the sampling point
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge gwe);
        #1;
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_lc4_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "lc4_consts.svh"

module tb_lc4_core;

    import lc4_pkg::*;

    localparam int CLK_PERIOD_NS = 8;
    localparam int N_REG         = 150;
    localparam int N_IMM         = 100;
    localparam int N_UNKNOWN     = 60;
    localparam int N_MIXED       = 150;
    localparam int N_TOTAL       = N_REG + N_IMM + N_UNKNOWN + N_MIXED;
    // margin covers reset, the idle window and the quiet tail
    localparam int WATCHDOG_CYCLES = 40 * N_TOTAL + 200;

    localparam int MODE_REG     = 0;
    localparam int MODE_IMM     = 1;
    localparam int MODE_UNKNOWN = 2;
    localparam int MODE_MIXED   = 3;

    logic    gwe;
    logic    i_arst_n;
    logic    i_insn_valid;
    word_t   i_insn;
    logic    o_insn_credit;
    logic    i_retire_credit;
    logic    o_retire_valid;
    retire_t o_retire;

    logic [31:0] rng_state = 32'hf18c;
    word_t       model_regs [8];
    retire_t     exp_q [$];
    reg_sel_t    last_rd;
    int          mode;
    int          send_left;
    int          snd_credits;
    int          sent;
    int          returned;
    int          owed;
    int          hold_left;
    logic        bp_enable;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (2)
    ) u_clock (
        .gwe      (gwe),
        .o_arst_n (i_arst_n)
    );

    lc4_core i_lc4_core (
        .gwe             (gwe),
        .i_arst_n        (i_arst_n),
        .i_insn_valid    (i_insn_valid),
        .i_insn          (i_insn),
        .o_insn_credit   (o_insn_credit),
        .i_retire_credit (i_retire_credit),
        .o_retire_valid  (o_retire_valid),
        .o_retire        (o_retire)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // upper LCG bits are the better distributed ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'({8'h00, r[31:8]}) % n;
    endfunction

    function automatic logic [2:0] nzp_of(input word_t value);
        if (value[15]) return 3'b100;
        else if (value == 16'h0000) return 3'b010;
        else return 3'b001;
    endfunction

    // half the sources reuse the last destination to hit the bypasses
    function automatic reg_sel_t pick_src();
        if (rand_below(2) == 0) return last_rd;
        else return reg_sel_t'(rand_below(8));
    endfunction

    function automatic word_t gen_reg_form();
        reg_sel_t rd;
        reg_sel_t rs;
        reg_sel_t rt;
        word_t    insn;
        rd = reg_sel_t'(rand_below(8));
        rs = pick_src();
        rt = pick_src();
        case (rand_below(6))
            0: insn = {`LC4_OP_ARITH, rd, rs, 3'b000, rt};
            1: insn = {`LC4_OP_ARITH, rd, rs, 3'b010, rt};
            2: insn = {`LC4_OP_LOGIC, rd, rs, 3'b000, rt};
            3: insn = {`LC4_OP_LOGIC, rd, rs, 3'b001, rt};
            4: insn = {`LC4_OP_LOGIC, rd, rs, 3'b010, rt};
            default: insn = {`LC4_OP_LOGIC, rd, rs, 3'b011, rt};
        endcase
        return insn;
    endfunction

    function automatic word_t gen_imm_form();
        reg_sel_t   rd;
        reg_sel_t   rs;
        logic [8:0] imm;
        word_t      insn;
        rd  = reg_sel_t'(rand_below(8));
        rs  = pick_src();
        imm = 9'(rand_below(512));
        case (rand_below(3))
            0: insn = {`LC4_OP_ARITH, rd, rs, 1'b1, imm[4:0]};
            1: insn = {`LC4_OP_LOGIC, rd, rs, 1'b1, imm[4:0]};
            default: insn = {`LC4_OP_CONST, rd, imm};
        endcase
        return insn;
    endfunction

    function automatic word_t gen_unknown();
        logic [3:0] op;
        op = 4'(rand_below(16));
        // step off the three kept opcodes
        if (op == `LC4_OP_ARITH || op == `LC4_OP_LOGIC || op == `LC4_OP_CONST) op = op + 4'd1;
        return {op, 12'(rand_below(4096))};
    endfunction

    function automatic word_t gen_insn(input int m);
        int    pick;
        word_t insn;
        pick = rand_below(4);
        if (m == MODE_REG) insn = gen_reg_form();
        else if (m == MODE_IMM) insn = gen_imm_form();
        else if (pick == 0 || (m == MODE_UNKNOWN && pick == 1)) insn = gen_unknown();
        else if (pick == 3) insn = gen_imm_form();
        else insn = gen_reg_form();
        return insn;
    endfunction

    // reference model, executes each sent instruction in order
    task automatic model_issue(input word_t insn);
        retire_t rec;
        word_t   a;
        word_t   b;
        word_t   imm5;
        word_t   imm9;
        word_t   res;
        logic    we;
        a    = model_regs[insn[8:6]];
        b    = model_regs[insn[2:0]];
        imm5 = {{11{insn[4]}}, insn[4:0]};
        imm9 = {{7{insn[8]}}, insn[8:0]};
        res  = 16'h0000;
        we   = 1'b1;
        case (insn[15:12])
            `LC4_OP_ARITH: begin
                if (insn[5]) res = a + imm5;
                else if (insn[4:3] == 2'b00) res = a + b;
                else if (insn[4:3] == 2'b10) res = a - b;
                // MUL and DIV are not part of the subset
                else we = 1'b0;
            end
            `LC4_OP_LOGIC: begin
                if (insn[5]) res = a & imm5;
                else if (insn[4:3] == 2'b00) res = a & b;
                else if (insn[4:3] == 2'b01) res = ~a;
                else if (insn[4:3] == 2'b10) res = a | b;
                else res = a ^ b;
            end
            `LC4_OP_CONST: res = imm9;
            default: we = 1'b0;
        endcase
        rec.insn    = insn;
        rec.rd_we   = we;
        rec.rd_sel  = insn[11:9];
        rec.rd_data = res;
        rec.nzp     = we ? nzp_of(res) : 3'b000;
        if (we) model_regs[insn[11:9]] = res;
        exp_q.push_back(rec);
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("MISMATCH at time %0d ns: %s got %h expected %h",
                               $time, name, got, expected));
        end
    endtask

    task automatic check_record(input retire_t got);
        retire_t want;
        if (exp_q.size() == 0) begin
            fail_run("retire record arrived with no instruction outstanding");
        end else begin
            want = exp_q.pop_front();
            check_value("o_retire.insn", got.insn, want.insn);
            check_value("o_retire.rd_we", 16'(got.rd_we), 16'(want.rd_we));
            // no-ops leave select, data and NZP undefined
            if (want.rd_we) begin
                check_value("o_retire.rd_sel", 16'(got.rd_sel), 16'(want.rd_sel));
                check_value("o_retire.rd_data", got.rd_data, want.rd_data);
                check_value("o_retire.nzp", 16'(got.nzp), 16'(want.nzp));
            end
        end
    endtask

    // one clock: sample the registered outputs, then drive both sides
    task automatic run_cycle();
        @(posedge gwe);
        #1;
        if (o_insn_credit) begin
            snd_credits++;
            returned++;
            if (snd_credits > `LC4_INSN_QUEUE_DEPTH) begin
                fail_run("input credit returned beyond the queue depth");
            end
        end
        if (o_retire_valid) begin
            if (owed >= `LC4_RETIRE_CREDITS) begin
                fail_run("retire record sent while the core held no consumer credit");
            end else begin
                check_record(o_retire);
                owed++;
            end
        end
        i_retire_credit = 1'b0;
        if (hold_left > 0) hold_left--;
        else if (bp_enable && rand_below(16) == 0) hold_left = 10 + rand_below(30);
        else if (owed > 0 && rand_below(4) != 0) begin
            i_retire_credit = 1'b1;
            owed--;
        end
        i_insn_valid = 1'b0;
        if (send_left > 0 && snd_credits > 0 && rand_below(4) != 0) begin
            i_insn       = gen_insn(mode);
            i_insn_valid = 1'b1;
            model_issue(i_insn);
            last_rd = i_insn[11:9];
            snd_credits--;
            send_left--;
            sent++;
        end
    endtask

    task automatic run_phase(input int phase_mode, input int count, input logic backpressure);
        mode      = phase_mode;
        send_left = count;
        bp_enable = backpressure;
        while (send_left > 0) run_cycle();
    endtask

    task automatic drain();
        bp_enable = 1'b0;
        hold_left = 0;
        while (exp_q.size() != 0) run_cycle();
        // quiet tail catches duplicate records or stray credits
        repeat (20) run_cycle();
    endtask

    initial begin
        i_insn_valid    = 1'b0;
        i_insn          = 16'h0000;
        i_retire_credit = 1'b0;
        mode            = MODE_REG;
        send_left       = 0;
        snd_credits     = `LC4_INSN_QUEUE_DEPTH;
        sent            = 0;
        returned        = 0;
        owed            = 0;
        hold_left       = 0;
        bp_enable       = 1'b0;
        last_rd         = 3'd0;
        for (int i = 0; i < 8; i++) model_regs[i] = 16'h0000;
        wait (i_arst_n === 1'b1);
        // no traffic yet, so both strobes stay low
        repeat (10) begin
            @(posedge gwe);
            #1;
            check_value("o_insn_credit", 16'(o_insn_credit), 16'h0000);
            check_value("o_retire_valid", 16'(o_retire_valid), 16'h0000);
        end
        run_phase(MODE_REG, N_REG, 1'b0);
        run_phase(MODE_IMM, N_IMM, 1'b0);
        run_phase(MODE_UNKNOWN, N_UNKNOWN, 1'b0);
        run_phase(MODE_MIXED, N_MIXED, 1'b1);
        drain();
        check_value("input credits returned", 16'(returned), 16'(sent));
        check_value("sender credit count", 16'(snd_credits), 16'(`LC4_INSN_QUEUE_DEPTH));
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        fail_run($sformatf("watchdog expired after %0d cycles, retire stream did not finish",
                           WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/lc4_pkg.sv
src/credit_fifo.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_pipeline.sv
src/retire_port.sv
src/lc4_core.sv
testbench/tb_clock.sv
testbench/tb_lc4_core.sv

// ==== Makefile ====
SIM       := verilator
TOP       := tb_lc4_core
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert -Wall
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
